//--- list.f
waw_pkg.sv
issue_pc_table.sv
stage_conflict_check.sv
hazard_reporter.sv
waw_hazard_monitor.sv
tb_waw_hazard_monitor.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf "$OBJ_DIR" "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -f list.f \
  --top-module tb_waw_hazard_monitor -Mdir "$OBJ_DIR" -o sim \
  > "$BUILD_LOG" 2>&1 \
  && "./$OBJ_DIR/sim" > "$SIM_LOG" 2>&1 \
  || { echo "Build or simulation did not complete"; cat "$BUILD_LOG" "$SIM_LOG" 2>/dev/null; exit 1; }

cat "$SIM_LOG"

grep -qF "*** TEST FAILED ***" "$SIM_LOG" \
  && { echo "Simulation reported a failure"; exit 1; } \
  || { echo "Simulation finished without failure"; exit 0; }

//--- tb_waw_hazard_monitor.sv
module tb_waw_hazard_monitor;

  timeunit 1ns;
  timeprecision 1ps;

  import waw_pkg::*;

  localparam int NUM_CYCLES   = 2000;
  localparam int IDLE_TIMEOUT = 20;

  logic                      clk_i;
  logic                      reset_i;
  logic                      remote_req_v_i;
  logic                      remote_req_yumi_i;
  logic                      remote_req_write_i;
  logic [REG_ADDR_WIDTH-1:0] remote_req_rd_i;
  logic [PC_WIDTH-1:0]       exe_pc_i;
  logic                      resp_v_i;
  logic                      resp_force_i;
  logic [REG_ADDR_WIDTH-1:0] resp_rd_i;
  logic                      mem_writes_rf_i;
  logic [REG_ADDR_WIDTH-1:0] mem_rd_i;
  logic                      wb_writes_rf_i;
  logic [REG_ADDR_WIDTH-1:0] wb_rd_i;
  logic                      exe_writes_rf_i;
  logic                      stall_i;

  logic                      hazard_o;
  hazard_src_e               hazard_src_o;
  logic [REG_ADDR_WIDTH-1:0] hazard_rd_o;
  logic [PC_WIDTH-1:0]       aggressor_pc_o;
  logic [PC_WIDTH-1:0]       victim_pc_o;
  logic [COUNT_WIDTH-1:0]    hazard_count_o;

  // Reference model of both tables and of the next report
  logic [PC_WIDTH-1:0]       model_aggressor [REG_ELS];
  logic [PC_WIDTH-1:0]       model_victim    [REG_ELS];
  logic                      exp_hazard;
  hazard_src_e               exp_src;
  logic [REG_ADDR_WIDTH-1:0] exp_rd;
  logic [PC_WIDTH-1:0]       exp_aggressor_pc;
  logic [PC_WIDTH-1:0]       exp_victim_pc;
  logic [COUNT_WIDTH-1:0]    exp_count;

  int checks_done;
  int error_count;
  int timeout_count;
  int hazards_seen;

  waw_hazard_monitor waw_hazard_monitor_inst (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .remote_req_v_i     (remote_req_v_i),
    .remote_req_yumi_i  (remote_req_yumi_i),
    .remote_req_write_i (remote_req_write_i),
    .remote_req_rd_i    (remote_req_rd_i),
    .exe_pc_i           (exe_pc_i),
    .resp_v_i           (resp_v_i),
    .resp_force_i       (resp_force_i),
    .resp_rd_i          (resp_rd_i),
    .mem_writes_rf_i    (mem_writes_rf_i),
    .mem_rd_i           (mem_rd_i),
    .wb_writes_rf_i     (wb_writes_rf_i),
    .wb_rd_i            (wb_rd_i),
    .exe_writes_rf_i    (exe_writes_rf_i),
    .stall_i            (stall_i),
    .hazard_o           (hazard_o),
    .hazard_src_o       (hazard_src_o),
    .hazard_rd_o        (hazard_rd_o),
    .aggressor_pc_o     (aggressor_pc_o),
    .victim_pc_o        (victim_pc_o),
    .hazard_count_o     (hazard_count_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic bit_equals(input string name, input logic exp, input logic act);
    checks_done++;
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic pc_equals(input string name, input logic [PC_WIDTH-1:0] exp,
                           input logic [PC_WIDTH-1:0] act);
    checks_done++;
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic reg_equals(input string name, input logic [REG_ADDR_WIDTH-1:0] exp,
                            input logic [REG_ADDR_WIDTH-1:0] act);
    checks_done++;
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic src_equals(input string name, input hazard_src_e exp, input hazard_src_e act);
    checks_done++;
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected %s, got %s (%b)",
               $time, name, exp.name(), act.name(), act);
    end
  endtask

  task automatic count_equals(input string name, input logic [COUNT_WIDTH-1:0] exp,
                              input logic [COUNT_WIDTH-1:0] act);
    checks_done++;
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic clear_inputs();
    remote_req_v_i     = 1'b0;
    remote_req_yumi_i  = 1'b0;
    remote_req_write_i = 1'b0;
    remote_req_rd_i    = '0;
    exe_pc_i           = '0;
    resp_v_i           = 1'b0;
    resp_force_i       = 1'b0;
    resp_rd_i          = '0;
    mem_writes_rf_i    = 1'b0;
    mem_rd_i           = '0;
    wb_writes_rf_i     = 1'b0;
    wb_rd_i            = '0;
    exe_writes_rf_i    = 1'b0;
    stall_i            = 1'b0;
  endtask

  // Registers come from x0..x3 and valid/force lean high to make hazards common
  task automatic drive_random_inputs();
    remote_req_v_i     = (($urandom % 4) != 0);
    remote_req_yumi_i  = (($urandom % 2) != 0);
    remote_req_write_i = (($urandom % 4) == 0);
    remote_req_rd_i    = REG_ADDR_WIDTH'($urandom % 4);
    exe_pc_i           = PC_WIDTH'($urandom);
    resp_v_i           = (($urandom % 4) != 0);
    resp_force_i       = (($urandom % 4) != 0);
    resp_rd_i          = REG_ADDR_WIDTH'($urandom % 4);
    mem_writes_rf_i    = (($urandom % 2) != 0);
    mem_rd_i           = REG_ADDR_WIDTH'($urandom % 4);
    wb_writes_rf_i     = (($urandom % 2) != 0);
    wb_rd_i            = REG_ADDR_WIDTH'($urandom % 4);
    exe_writes_rf_i    = (($urandom % 4) == 0);
    stall_i            = (($urandom % 4) == 0);
  endtask

  // Works out the report for the coming edge, then updates the tables
  task automatic predict_next();
    hazard_src_e               src;
    logic [REG_ADDR_WIDTH-1:0] hit_rd;
    src    = SRC_NONE;
    hit_rd = '0;
    if (resp_v_i && resp_force_i) begin
      if (mem_writes_rf_i) begin
        if (mem_rd_i == resp_rd_i) begin
          src    = SRC_MEM;
          hit_rd = mem_rd_i;
        end
      end else if (wb_writes_rf_i && (wb_rd_i == resp_rd_i)) begin
        src    = SRC_WB;
        hit_rd = wb_rd_i;
      end
    end
    exp_hazard       = (src != SRC_NONE);
    exp_src          = src;
    exp_rd           = hit_rd;
    exp_aggressor_pc = exp_hazard ? model_aggressor[hit_rd] : '0;
    exp_victim_pc    = exp_hazard ? model_victim[hit_rd] : '0;
    if (exp_hazard && (exp_count != '1)) begin
      exp_count = exp_count + COUNT_WIDTH'(1);
    end
    // Victim goes first so it takes the aggressor value from before the edge
    if (resp_v_i && !stall_i && !exe_writes_rf_i) begin
      model_victim[resp_rd_i] = model_aggressor[resp_rd_i];
    end
    if (remote_req_v_i && remote_req_yumi_i && !remote_req_write_i) begin
      model_aggressor[remote_req_rd_i] = exe_pc_i;
    end
  endtask

  task automatic compare_outputs();
    bit_equals("hazard_o", exp_hazard, hazard_o);
    src_equals("hazard_src_o", exp_src, hazard_src_o);
    reg_equals("hazard_rd_o", exp_rd, hazard_rd_o);
    pc_equals("aggressor_pc_o", exp_aggressor_pc, aggressor_pc_o);
    pc_equals("victim_pc_o", exp_victim_pc, victim_pc_o);
    count_equals("hazard_count_o", exp_count, hazard_count_o);
  endtask

  task automatic advance_cycle();
    @(negedge clk_i);
    if (hazard_o === 1'b1) begin
      hazards_seen++;
    end
    compare_outputs();
  endtask

  task automatic wait_until_quiet();
    int waited;
    waited = 0;
    do begin
      advance_cycle();
      clear_inputs();
      predict_next();
      waited++;
    end while ((hazard_o !== 1'b0) && (waited < IDLE_TIMEOUT));
    if (hazard_o !== 1'b0) begin
      timeout_count++;
      $display("Timeout: hazard_o did not return low within %0d idle cycles", IDLE_TIMEOUT);
    end
  endtask

  initial begin
    checks_done   = 0;
    error_count   = 0;
    timeout_count = 0;
    hazards_seen  = 0;
    void'($urandom(32'h8bba_3aed));
    clk_i   = 1'b0;
    reset_i = 1'b1;
    clear_inputs();
    for (int i = 0; i < REG_ELS; i++) begin
      model_aggressor[i] = '0;
      model_victim[i]    = '0;
    end
    exp_hazard       = 1'b0;
    exp_src          = SRC_NONE;
    exp_rd           = '0;
    exp_aggressor_pc = '0;
    exp_victim_pc    = '0;
    exp_count        = '0;

    repeat (4) @(negedge clk_i);
    compare_outputs();
    reset_i = 1'b0;
    predict_next();

    // Two loads to x2; the second accept lands with the response retiring,
    // so the victim keeps the first PC
    advance_cycle();
    clear_inputs();
    remote_req_v_i    = 1'b1;
    remote_req_yumi_i = 1'b1;
    remote_req_rd_i   = 5'd2;
    exe_pc_i          = 32'h0000_1000;
    predict_next();
    advance_cycle();
    clear_inputs();
    remote_req_v_i    = 1'b1;
    remote_req_yumi_i = 1'b1;
    remote_req_rd_i   = 5'd2;
    exe_pc_i          = 32'h0000_2000;
    resp_v_i          = 1'b1;
    resp_rd_i         = 5'd2;
    predict_next();

    // A store and an unaccepted load leave the aggressor entry alone
    advance_cycle();
    clear_inputs();
    remote_req_v_i     = 1'b1;
    remote_req_yumi_i  = 1'b1;
    remote_req_write_i = 1'b1;
    remote_req_rd_i    = 5'd2;
    exe_pc_i           = 32'h0000_3000;
    predict_next();
    advance_cycle();
    clear_inputs();
    remote_req_v_i  = 1'b1;
    remote_req_rd_i = 5'd2;
    exe_pc_i        = 32'h0000_4000;
    predict_next();

    // MEM writes x5, so the WB match on x2 must be ignored
    advance_cycle();
    clear_inputs();
    resp_v_i        = 1'b1;
    resp_force_i    = 1'b1;
    resp_rd_i       = 5'd2;
    mem_writes_rf_i = 1'b1;
    mem_rd_i        = 5'd5;
    wb_writes_rf_i  = 1'b1;
    wb_rd_i         = 5'd2;
    stall_i         = 1'b1;
    predict_next();
    advance_cycle();
    clear_inputs();
    resp_v_i       = 1'b1;
    resp_force_i   = 1'b1;
    resp_rd_i      = 5'd2;
    wb_writes_rf_i = 1'b1;
    wb_rd_i        = 5'd2;
    stall_i        = 1'b1;
    predict_next();
    advance_cycle();
    src_equals("hazard_src_o (WB only)", SRC_WB, hazard_src_o);
    pc_equals("aggressor_pc_o (last load)", 32'h0000_2000, aggressor_pc_o);
    pc_equals("victim_pc_o (old value)", 32'h0000_1000, victim_pc_o);
    clear_inputs();
    predict_next();

    for (int i = 0; i < NUM_CYCLES; i++) begin
      advance_cycle();
      drive_random_inputs();
      predict_next();
    end

    wait_until_quiet();
    count_equals("hazard_count_o vs reports seen", COUNT_WIDTH'(hazards_seen), hazard_count_o);

    $display("Checks: %0d, mismatches: %0d, timeouts: %0d, hazards reported: %0d",
             checks_done, error_count, timeout_count, hazards_seen);
    if ((error_count == 0) && (timeout_count == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- waw_hazard_monitor.sv
module waw_hazard_monitor (
  input  logic                               clk_i,
  input  logic                               reset_i,

  input  logic                               remote_req_v_i,
  input  logic                               remote_req_yumi_i,
  input  logic                               remote_req_write_i,
  input  logic [waw_pkg::REG_ADDR_WIDTH-1:0] remote_req_rd_i,
  input  logic [waw_pkg::PC_WIDTH-1:0]       exe_pc_i,

  input  logic                               resp_v_i,
  input  logic                               resp_force_i,
  input  logic [waw_pkg::REG_ADDR_WIDTH-1:0] resp_rd_i,

  input  logic                               mem_writes_rf_i,
  input  logic [waw_pkg::REG_ADDR_WIDTH-1:0] mem_rd_i,
  input  logic                               wb_writes_rf_i,
  input  logic [waw_pkg::REG_ADDR_WIDTH-1:0] wb_rd_i,
  input  logic                               exe_writes_rf_i,
  input  logic                               stall_i,

  output logic                               hazard_o,
  output waw_pkg::hazard_src_e               hazard_src_o,
  output logic [waw_pkg::REG_ADDR_WIDTH-1:0] hazard_rd_o,
  output logic [waw_pkg::PC_WIDTH-1:0]       aggressor_pc_o,
  output logic [waw_pkg::PC_WIDTH-1:0]       victim_pc_o,
  output logic [waw_pkg::COUNT_WIDTH-1:0]    hazard_count_o
);

  import waw_pkg::*;

  hazard_src_e               conflict_src;
  logic [REG_ADDR_WIDTH-1:0] conflict_rd;
  logic [REG_ADDR_WIDTH-1:0] rd_sel;
  logic [PC_WIDTH-1:0]       aggressor_pc;
  logic [PC_WIDTH-1:0]       victim_pc;

  issue_pc_table issue_pc_table_inst (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .remote_req_v_i     (remote_req_v_i),
    .remote_req_yumi_i  (remote_req_yumi_i),
    .remote_req_write_i (remote_req_write_i),
    .remote_req_rd_i    (remote_req_rd_i),
    .exe_pc_i           (exe_pc_i),
    .resp_v_i           (resp_v_i),
    .stall_i            (stall_i),
    .exe_writes_rf_i    (exe_writes_rf_i),
    .resp_rd_i          (resp_rd_i),
    .rd_sel_i           (rd_sel),
    .aggressor_pc_o     (aggressor_pc),
    .victim_pc_o        (victim_pc)
  );

  stage_conflict_check stage_conflict_check_inst (
    .resp_v_i        (resp_v_i),
    .resp_force_i    (resp_force_i),
    .resp_rd_i       (resp_rd_i),
    .mem_writes_rf_i (mem_writes_rf_i),
    .mem_rd_i        (mem_rd_i),
    .wb_writes_rf_i  (wb_writes_rf_i),
    .wb_rd_i         (wb_rd_i),
    .conflict_src_o  (conflict_src),
    .conflict_rd_o   (conflict_rd)
  );

  // The reporter closes the loop back into the table read port
  hazard_reporter hazard_reporter_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .conflict_src_i (conflict_src),
    .conflict_rd_i  (conflict_rd),
    .rd_sel_o       (rd_sel),
    .aggressor_pc_i (aggressor_pc),
    .victim_pc_i    (victim_pc),
    .hazard_o       (hazard_o),
    .hazard_src_o   (hazard_src_o),
    .hazard_rd_o    (hazard_rd_o),
    .aggressor_pc_o (aggressor_pc_o),
    .victim_pc_o    (victim_pc_o),
    .hazard_count_o (hazard_count_o)
  );

endmodule

//--- hazard_reporter.sv
module hazard_reporter (
  input  logic                               clk_i,
  input  logic                               reset_i,

  input  waw_pkg::hazard_src_e               conflict_src_i,
  input  logic [waw_pkg::REG_ADDR_WIDTH-1:0] conflict_rd_i,

  output logic [waw_pkg::REG_ADDR_WIDTH-1:0] rd_sel_o,
  input  logic [waw_pkg::PC_WIDTH-1:0]       aggressor_pc_i,
  input  logic [waw_pkg::PC_WIDTH-1:0]       victim_pc_i,

  output logic                               hazard_o,
  output waw_pkg::hazard_src_e               hazard_src_o,
  output logic [waw_pkg::REG_ADDR_WIDTH-1:0] hazard_rd_o,
  output logic [waw_pkg::PC_WIDTH-1:0]       aggressor_pc_o,
  output logic [waw_pkg::PC_WIDTH-1:0]       victim_pc_o,
  output logic [waw_pkg::COUNT_WIDTH-1:0]    hazard_count_o
);

  import waw_pkg::*;

  logic                      hazard_r;
  hazard_src_e               hazard_src_r;
  logic [REG_ADDR_WIDTH-1:0] hazard_rd_r;
  logic [PC_WIDTH-1:0]       aggressor_pc_r;
  logic [PC_WIDTH-1:0]       victim_pc_r;
  logic [COUNT_WIDTH-1:0]    hazard_count_r;

  logic conflict;

  assign conflict = (conflict_src_i != SRC_NONE);

  // Point the table read port at the colliding register so the PCs
  // are sampled in the same cycle as the conflict
  assign rd_sel_o = conflict_rd_i;

  // One-cycle report, cleared again when the next cycle is clean
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hazard_r       <= 1'b0;
      hazard_src_r   <= SRC_NONE;
      hazard_rd_r    <= '0;
      aggressor_pc_r <= '0;
      victim_pc_r    <= '0;
    end else if (conflict) begin
      hazard_r       <= 1'b1;
      hazard_src_r   <= conflict_src_i;
      hazard_rd_r    <= conflict_rd_i;
      aggressor_pc_r <= aggressor_pc_i;
      victim_pc_r    <= victim_pc_i;
    end else begin
      hazard_r       <= 1'b0;
      hazard_src_r   <= SRC_NONE;
      hazard_rd_r    <= '0;
      aggressor_pc_r <= '0;
      victim_pc_r    <= '0;
    end
  end

  // Saturating count, sticks at all ones
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hazard_count_r <= '0;
    end else if (conflict && (hazard_count_r != '1)) begin
      hazard_count_r <= hazard_count_r + COUNT_WIDTH'(1);
    end
  end

  assign hazard_o       = hazard_r;
  assign hazard_src_o   = hazard_src_r;
  assign hazard_rd_o    = hazard_rd_r;
  assign aggressor_pc_o = aggressor_pc_r;
  assign victim_pc_o    = victim_pc_r;
  assign hazard_count_o = hazard_count_r;

  assert property (
    @(posedge clk_i) disable iff (reset_i)
    hazard_o == (hazard_src_o != SRC_NONE)
  ) else $error("hazard_reporter: hazard_o disagrees with hazard_src_o");

endmodule

//--- stage_conflict_check.sv
module stage_conflict_check (
  input  logic                               resp_v_i,
  input  logic                               resp_force_i,
  input  logic [waw_pkg::REG_ADDR_WIDTH-1:0] resp_rd_i,

  input  logic                               mem_writes_rf_i,
  input  logic [waw_pkg::REG_ADDR_WIDTH-1:0] mem_rd_i,
  input  logic                               wb_writes_rf_i,
  input  logic [waw_pkg::REG_ADDR_WIDTH-1:0] wb_rd_i,

  output waw_pkg::hazard_src_e               conflict_src_o,
  output logic [waw_pkg::REG_ADDR_WIDTH-1:0] conflict_rd_o
);

  import waw_pkg::*;

  logic forced_resp;
  logic mem_match;
  logic wb_match;

  // Only a forced response bypasses the normal write port arbitration
  assign forced_resp = resp_v_i & resp_force_i;

  assign mem_match = (resp_rd_i == mem_rd_i);
  assign wb_match  = (resp_rd_i == wb_rd_i);

  // MEM owns the priority: once it writes the register file, WB is
  // not looked at even when only WB would match
  always_comb begin
    conflict_src_o = SRC_NONE;
    conflict_rd_o  = '0;

    if (forced_resp) begin
      if (mem_writes_rf_i) begin
        if (mem_match) begin
          conflict_src_o = SRC_MEM;
          conflict_rd_o  = mem_rd_i;
        end
      end else if (wb_writes_rf_i) begin
        if (wb_match) begin
          conflict_src_o = SRC_WB;
          conflict_rd_o  = wb_rd_i;
        end
      end
    end
  end

endmodule

//--- issue_pc_table.sv
module issue_pc_table (
  input  logic                               clk_i,
  input  logic                               reset_i,

  input  logic                               remote_req_v_i,
  input  logic                               remote_req_yumi_i,
  input  logic                               remote_req_write_i,
  input  logic [waw_pkg::REG_ADDR_WIDTH-1:0] remote_req_rd_i,
  input  logic [waw_pkg::PC_WIDTH-1:0]       exe_pc_i,

  input  logic                               resp_v_i,
  input  logic                               stall_i,
  input  logic                               exe_writes_rf_i,
  input  logic [waw_pkg::REG_ADDR_WIDTH-1:0] resp_rd_i,

  input  logic [waw_pkg::REG_ADDR_WIDTH-1:0] rd_sel_i,
  output logic [waw_pkg::PC_WIDTH-1:0]       aggressor_pc_o,
  output logic [waw_pkg::PC_WIDTH-1:0]       victim_pc_o
);

  import waw_pkg::*;

  logic [PC_WIDTH-1:0] aggressor_pc_r [REG_ELS];
  logic [PC_WIDTH-1:0] victim_pc_r    [REG_ELS];

  logic req_accept;
  logic load_accept;
  logic victim_copy;

  // A request leaves the core only when the network takes it
  assign req_accept = remote_req_v_i & remote_req_yumi_i;

  // Stores carry no destination register, so only loads are tracked
  assign load_accept = req_accept & ~remote_req_write_i;

  // The response can only reach the register file when the pipeline leaves
  // the write port free: no stall and no instruction in EXE writing it
  assign victim_copy = resp_v_i & ~stall_i & ~exe_writes_rf_i;

  // PC of the most recent accepted remote load, per destination register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < REG_ELS; i++) begin
        aggressor_pc_r[i] <= '0;
      end
    end else if (load_accept) begin
      aggressor_pc_r[remote_req_rd_i] <= exe_pc_i;
    end
  end

  // The copy reads the aggressor entry before this edge, so an accept to
  // the same register in the same cycle does not leak into the victim
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < REG_ELS; i++) begin
        victim_pc_r[i] <= '0;
      end
    end else if (victim_copy) begin
      victim_pc_r[resp_rd_i] <= aggressor_pc_r[resp_rd_i];
    end
  end

  // Single combinational read port shared by both tables
  assign aggressor_pc_o = aggressor_pc_r[rd_sel_i];
  assign victim_pc_o    = victim_pc_r[rd_sel_i];

  // An accepted load must name a real register or the table gets corrupted
  assert property (
    @(posedge clk_i) disable iff (reset_i)
    req_accept |-> !$isunknown(remote_req_rd_i)
  ) else $error("issue_pc_table: remote_req_rd_i unknown on an accepted request");

endmodule

//--- waw_pkg.sv
package waw_pkg;

  // Program counter width of the core
  localparam int PC_WIDTH = 32;

  // Architectural register index width
  localparam int REG_ADDR_WIDTH = 5;

  // One table entry per architectural register
  localparam int REG_ELS = 32;

  // Width of the saturating hazard counter
  localparam int COUNT_WIDTH = 16;

  // Pipeline stage that collided with a forced remote response
  typedef enum logic [1:0] {
    SRC_NONE = 2'b00,
    SRC_MEM  = 2'b01,
    SRC_WB   = 2'b10
  } hazard_src_e;

endpackage
